// File: flist.f
hdl/lsu_pkg.sv
hdl/dcache_pkg.sv
hdl/lsu_access.sv
hdl/amo_alu.sv
hdl/lsu_amo.sv
hdl/lsu_port_arbiter.sv
hdl/lsu_top.sv
testbench/tb_lsu.sv

// File: hdl/amo_alu.sv
`timescale 1ns/1ps

module amo_alu (
    input  lsu_pkg::amo_op_e op_i,
    input  lsu_pkg::word_t   old_i,
    input  lsu_pkg::word_t   src_i,
    output lsu_pkg::word_t   new_o
);

    logic old_lt_s;
    logic old_lt_u;

    // old value against rs2, both ways
    assign old_lt_s = $signed(old_i) < $signed(src_i);
    assign old_lt_u = old_i < src_i;

    always_comb begin
        case (op_i)
            lsu_pkg::SWAP: new_o = src_i;
            lsu_pkg::ADD:  new_o = old_i + src_i;
            lsu_pkg::XOR:  new_o = old_i ^ src_i;
            lsu_pkg::AND:  new_o = old_i & src_i;
            lsu_pkg::OR:   new_o = old_i | src_i;
            // min keeps the smaller, max the larger
            lsu_pkg::MIN:  new_o = old_lt_s ? old_i : src_i;
            lsu_pkg::MAX:  new_o = old_lt_s ? src_i : old_i;
            lsu_pkg::MINU: new_o = old_lt_u ? old_i : src_i;
            lsu_pkg::MAXU: new_o = old_lt_u ? src_i : old_i;
            // unknown codes behave like swap
            default:       new_o = src_i;
        endcase
    end

endmodule

// File: hdl/dcache_pkg.sv
package dcache_pkg;

    // one bit per byte lane
    typedef logic [3:0] byte_mask_t;
    // one-hot access size, bit0 byte, bit1 half, bit2 word
    typedef logic [3:0] size_t;

    // unshifted lane masks
    localparam byte_mask_t MASK_B = 4'b0001;
    localparam byte_mask_t MASK_H = 4'b0011;
    localparam byte_mask_t MASK_W = 4'b1111;

    // size codes
    localparam size_t SIZE_B = 4'b0001;
    localparam size_t SIZE_H = 4'b0010;
    localparam size_t SIZE_W = 4'b0100;

    // request toward the data cache, valid held until ready
    typedef struct packed {
        logic          valid;
        logic          write;
        lsu_pkg::word_t addr;
        byte_mask_t    mask;
        size_t         size;
        lsu_pkg::word_t wdata;
    } dcache_req_t;

    // answer from the data cache
    typedef struct packed {
        logic           ready;
        lsu_pkg::word_t rdata;
    } dcache_resp_t;

endpackage

// File: hdl/lsu_access.sv
`timescale 1ns/1ps

module lsu_access (
    input  lsu_pkg::lsu_req_t        req_i,
    input  dcache_pkg::dcache_resp_t resp_i,
    output dcache_pkg::dcache_req_t  plain_req_o,
    output lsu_pkg::word_t           plain_data_o,
    output logic                     plain_store_o
);

    logic op_none;
    logic op_b;
    logic op_h;
    logic op_w;
    logic is_load;
    logic is_store;
    logic is_signed;
    dcache_pkg::size_t      size;
    dcache_pkg::byte_mask_t base_mask;
    dcache_pkg::byte_mask_t wmask;
    lsu_pkg::word_t         rdata;
    lsu_pkg::word_t         rdata_ext;

    // plain op decode, atomics are left to lsu_amo
    assign op_none = (req_i.mem_op == lsu_pkg::NONE);
    assign op_b = (req_i.mem_op == lsu_pkg::LB) | (req_i.mem_op == lsu_pkg::LBU) |
                  (req_i.mem_op == lsu_pkg::SB);
    assign op_h = (req_i.mem_op == lsu_pkg::LH) | (req_i.mem_op == lsu_pkg::LHU) |
                  (req_i.mem_op == lsu_pkg::SH);
    assign op_w = (req_i.mem_op == lsu_pkg::LW) | (req_i.mem_op == lsu_pkg::SW);

    assign is_store = (req_i.mem_op == lsu_pkg::SB) | (req_i.mem_op == lsu_pkg::SH) |
                      (req_i.mem_op == lsu_pkg::SW);
    assign is_load = (op_b | op_h | op_w) & ~is_store;
    // sign extension for lb and lh
    assign is_signed = (req_i.mem_op == lsu_pkg::LB) | (req_i.mem_op == lsu_pkg::LH);

    // one-hot size from the width flags
    assign size = ({4{op_b}} & dcache_pkg::SIZE_B) |
                  ({4{op_h}} & dcache_pkg::SIZE_H) |
                  ({4{op_w}} & dcache_pkg::SIZE_W);

    assign base_mask = ({4{size[0]}} & dcache_pkg::MASK_B) |
                       ({4{size[1]}} & dcache_pkg::MASK_H) |
                       ({4{size[2]}} & dcache_pkg::MASK_W);
    // stores move the mask into the addressed lanes
    assign wmask = base_mask << req_i.addr[1:0];

    // level request, dropped in the ready cycle
    assign plain_req_o.valid = (is_load | is_store) & ~resp_i.ready;
    assign plain_req_o.write = is_store & plain_req_o.valid;
    assign plain_req_o.addr  = req_i.addr;
    assign plain_req_o.mask  = is_store ? wmask : base_mask;
    assign plain_req_o.size  = size;
    // store data into its byte lane
    assign plain_req_o.wdata = req_i.wdata << {req_i.addr[1:0], 3'b000};

    // read data arrives right-aligned, only sampled with ready
    assign rdata = resp_i.ready ? resp_i.rdata : '0;

    always_comb begin
        if (size[0]) begin
            rdata_ext = is_signed ? {{24{rdata[7]}}, rdata[7:0]} : {24'b0, rdata[7:0]};
        end else if (size[1]) begin
            rdata_ext = is_signed ? {{16{rdata[15]}}, rdata[15:0]} : {16'b0, rdata[15:0]};
        end else begin
            rdata_ext = rdata;
        end
    end

    // non-memory ops hand the alu result on
    assign plain_data_o = is_load ? rdata_ext : (op_none ? req_i.addr : '0);

    // tells the atomic path to drop its reservation
    assign plain_store_o = is_store;

endmodule

// File: hdl/lsu_amo.sv
`timescale 1ns/1ps

module lsu_amo (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::lsu_req_t        req_i,
    input  dcache_pkg::dcache_resp_t resp_i,
    input  logic                     plain_store_i,
    output dcache_pkg::dcache_req_t  amo_req_o,
    output lsu_pkg::word_t           amo_result_o,
    output logic                     amo_busy_o,
    output logic                     amo_done_o
);

    lsu_pkg::amo_state_e state_q;
    logic           done_q;
    logic           resv_valid_q;
    lsu_pkg::word_t resv_addr_q;
    lsu_pkg::word_t loaded_q;
    lsu_pkg::word_t calc_q;
    lsu_pkg::word_t result_q;
    lsu_pkg::word_t alu_new;
    logic is_lr;
    logic is_sc;
    logic is_amo;
    logic is_atomic;
    logic start;
    logic sc_ok;

    assign is_lr     = (req_i.mem_op == lsu_pkg::LR_W);
    assign is_sc     = (req_i.mem_op == lsu_pkg::SC_W);
    assign is_amo    = (req_i.mem_op == lsu_pkg::AMO);
    assign is_atomic = is_lr | is_sc | is_amo;

    // new request only in idle and not in the done cycle
    assign start = (state_q == lsu_pkg::IDLE) & is_atomic & ~done_q;

    // sc needs a live reservation on the same word
    assign sc_ok = resv_valid_q & (resv_addr_q == req_i.addr);

    amo_alu i_amo_alu (
        .op_i  (req_i.amo_op),
        .old_i (loaded_q),
        .src_i (req_i.wdata),
        .new_o (alu_new)
    );

    // sequencer and reservation flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= lsu_pkg::IDLE;
            done_q       <= 1'b0;
            resv_valid_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                lsu_pkg::IDLE: begin
                    if (start && (is_lr || is_amo)) begin
                        state_q      <= lsu_pkg::LOAD;
                        resv_valid_q <= 1'b1;
                    end else if (start && sc_ok) begin
                        state_q <= lsu_pkg::STORE;
                    end else if (start) begin
                        // failed sc, no cache access at all
                        done_q       <= 1'b1;
                        resv_valid_q <= 1'b0;
                    end
                end
                lsu_pkg::LOAD: begin
                    if (resp_i.ready) begin
                        if (is_lr) begin
                            state_q <= lsu_pkg::IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= lsu_pkg::CALC;
                        end
                    end
                end
                // single cycle for the alu result
                lsu_pkg::CALC: begin
                    state_q <= lsu_pkg::STORE;
                end
                lsu_pkg::STORE: begin
                    if (resp_i.ready) begin
                        state_q      <= lsu_pkg::IDLE;
                        done_q       <= 1'b1;
                        resv_valid_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= lsu_pkg::IDLE;
                end
            endcase
            // any plain store kills the reservation
            if (plain_store_i) begin
                resv_valid_q <= 1'b0;
            end
        end
    end

    // data side
    always_ff @(posedge clk) begin
        if (start && (is_lr || is_amo)) begin
            resv_addr_q <= req_i.addr;
        end
        if (start && is_sc && !sc_ok) begin
            result_q <= lsu_pkg::SC_FAIL_CODE;
        end
        // lr and amo both return the old word
        if (state_q == lsu_pkg::LOAD && resp_i.ready) begin
            loaded_q <= resp_i.rdata;
            result_q <= resp_i.rdata;
        end
        if (state_q == lsu_pkg::CALC) begin
            calc_q <= alu_new;
        end
        if (state_q == lsu_pkg::STORE && resp_i.ready && is_sc) begin
            result_q <= lsu_pkg::SC_OK_CODE;
        end
    end

    // word accesses only, addresses taken as aligned
    assign amo_req_o.valid = ((state_q == lsu_pkg::LOAD) | (state_q == lsu_pkg::STORE)) &
                             ~resp_i.ready;
    assign amo_req_o.write = (state_q == lsu_pkg::STORE);
    assign amo_req_o.addr  = req_i.addr;
    assign amo_req_o.mask  = dcache_pkg::MASK_W;
    assign amo_req_o.size  = dcache_pkg::SIZE_W;
    // sc stores rs2, amo stores the computed word
    assign amo_req_o.wdata = is_sc ? req_i.wdata : calc_q;

    assign amo_result_o = result_q;
    assign amo_done_o   = done_q;
    // low again in the done cycle so the pipeline moves on
    assign amo_busy_o   = (state_q != lsu_pkg::IDLE) | start;

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    // data or address word of the rv32 pipeline
    typedef logic [31:0] word_t;

    // memory operation from the execute stage
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LBU  = 4'd2,
        LH   = 4'd3,
        LHU  = 4'd4,
        LW   = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8,
        LR_W = 4'd9,
        SC_W = 4'd10,
        AMO  = 4'd11
    } mem_op_e;

    // funct5 group of the amo instructions, flattened
    typedef enum logic [3:0] {
        SWAP = 4'd0,
        ADD  = 4'd1,
        XOR  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        MIN  = 4'd5,
        MAX  = 4'd6,
        MINU = 4'd7,
        MAXU = 4'd8
    } amo_op_e;

    // stage request, held by the pipeline while stalled
    typedef struct packed {
        mem_op_e mem_op;
        amo_op_e amo_op;
        // alu result
        word_t   addr;
        // rs2
        word_t   wdata;
    } lsu_req_t;

    // atomic sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        CALC  = 2'd2,
        STORE = 2'd3
    } amo_state_e;

    // sc.w return codes written to rd
    localparam word_t SC_FAIL_CODE = 32'd1;
    localparam word_t SC_OK_CODE   = 32'd0;

endpackage

// File: hdl/lsu_port_arbiter.sv
`timescale 1ns/1ps

module lsu_port_arbiter (
    input  dcache_pkg::dcache_req_t plain_req_i,
    input  dcache_pkg::dcache_req_t amo_req_i,
    input  lsu_pkg::word_t          plain_data_i,
    input  lsu_pkg::word_t          amo_result_i,
    input  logic                    amo_busy_i,
    input  logic                    amo_done_i,
    output dcache_pkg::dcache_req_t dcache_req_o,
    output lsu_pkg::word_t          result_o,
    output logic                    stall_o
);

    // both paths never request together, atomic wins anyway
    always_comb begin
        if (amo_req_i.valid) begin
            dcache_req_o = amo_req_i;
        end else begin
            dcache_req_o = plain_req_i;
        end
    end

    // atomic result only for its done pulse
    assign result_o = amo_done_i ? amo_result_i : plain_data_i;

    // plain valid ends with ready, busy ends with done
    assign stall_o = plain_req_i.valid | amo_busy_i;

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::lsu_req_t        req_i,
    input  dcache_pkg::dcache_resp_t dcache_resp_i,
    output dcache_pkg::dcache_req_t  dcache_req_o,
    output lsu_pkg::word_t           result_o,
    output logic                     stall_o
);

    dcache_pkg::dcache_req_t plain_req;
    dcache_pkg::dcache_req_t amo_req;
    lsu_pkg::word_t          plain_data;
    lsu_pkg::word_t          amo_result;
    logic                    plain_store;
    logic                    amo_busy;
    logic                    amo_done;

    // byte, half and word loads and stores
    lsu_access i_lsu_access (
        .req_i         (req_i),
        .resp_i        (dcache_resp_i),
        .plain_req_o   (plain_req),
        .plain_data_o  (plain_data),
        .plain_store_o (plain_store)
    );

    // lr, sc and amo sequencer
    lsu_amo i_lsu_amo (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .resp_i        (dcache_resp_i),
        .plain_store_i (plain_store),
        .amo_req_o     (amo_req),
        .amo_result_o  (amo_result),
        .amo_busy_o    (amo_busy),
        .amo_done_o    (amo_done)
    );

    // shared cache port, result mux and stall
    lsu_port_arbiter i_lsu_port_arbiter (
        .plain_req_i  (plain_req),
        .amo_req_i    (amo_req),
        .plain_data_i (plain_data),
        .amo_result_i (amo_result),
        .amo_busy_i   (amo_busy),
        .amo_done_i   (amo_done),
        .dcache_req_o (dcache_req_o),
        .result_o     (result_o),
        .stall_o      (stall_o)
    );

endmodule

// File: testbench/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

    localparam int N_OPS = 400;
    localparam int TIMEOUT_CYCLES = N_OPS * 12;
    localparam lsu_pkg::word_t WIN_BASE = 32'h0000_2000;

    logic clk;
    logic rst;
    lsu_pkg::lsu_req_t        req;
    dcache_pkg::dcache_resp_t resp;
    dcache_pkg::dcache_req_t  dreq;
    lsu_pkg::word_t           result;
    logic                     stall;

    integer seed;
    int     cycle_count;
    int     ops_done;
    // cache model, 16 words seen by the dut
    logic [7:0] mem [0:63];
    dcache_pkg::dcache_req_t seen;
    dcache_pkg::dcache_req_t held;
    logic        waiting;
    logic [1:0]  delay;
    logic [31:0] roll;
    int          writes_seen;
    // reference copy and reservation
    logic [7:0] ref_mem [0:63];
    logic           resv_valid;
    lsu_pkg::word_t resv_addr;
    logic           prev_lr;
    // op in flight
    string                  cur_name;
    lsu_pkg::word_t         cur_addr;
    logic                   exp_write;
    dcache_pkg::byte_mask_t exp_mask;
    dcache_pkg::size_t      exp_size;
    lsu_pkg::word_t         exp_wdata;
    lsu_pkg::word_t         exp_result;
    logic                   result_valid;

    lsu_top i_lsu_top (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req),
        .dcache_resp_i (resp),
        .dcache_req_o  (dreq),
        .result_o      (result),
        .stall_o       (stall)
    );

    always #4 clk = ~clk;

    task automatic fail_run();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input lsu_pkg::word_t exp,
                              input lsu_pkg::word_t act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_mask(input string name, input dcache_pkg::byte_mask_t exp,
                              input dcache_pkg::byte_mask_t act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_size(input string name, input dcache_pkg::size_t exp,
                              input dcache_pkg::size_t act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    // atomic update rule, old word against rs2
    function automatic lsu_pkg::word_t amo_expect(input lsu_pkg::amo_op_e op,
                                                  input lsu_pkg::word_t old,
                                                  input lsu_pkg::word_t src);
        logic signed [31:0] so;
        logic signed [31:0] ss;
        so = old;
        ss = src;
        case (op)
            lsu_pkg::ADD:  return old + src;
            lsu_pkg::XOR:  return old ^ src;
            lsu_pkg::AND:  return old & src;
            lsu_pkg::OR:   return old | src;
            lsu_pkg::MIN:  return (so > ss) ? src : old;
            lsu_pkg::MAX:  return (so > ss) ? old : src;
            lsu_pkg::MINU: return (old > src) ? src : old;
            lsu_pkg::MAXU: return (old > src) ? old : src;
            // swap
            default:       return src;
        endcase
    endfunction

    function automatic lsu_pkg::word_t ref_word(input logic [5:0] off);
        return {ref_mem[off + 3], ref_mem[off + 2], ref_mem[off + 1], ref_mem[off]};
    endfunction

    // expected write, also applied to the reference copy
    task automatic ref_store(input logic [5:0] off, input dcache_pkg::byte_mask_t m,
                             input lsu_pkg::word_t d);
        for (int k = 0; k < 4; k++) begin
            if (m[k]) begin
                ref_mem[{off[5:2], 2'b00} + k] = d[8*k +: 8];
            end
        end
        exp_write = 1'b1;
        exp_mask = m;
        exp_wdata = d;
    endtask

    // answer the latched request, raise ready for one cycle
    task automatic serve_access();
        lsu_pkg::word_t rd;
        logic [5:0]     off;
        off = held.addr[5:0];
        rd = '0;
        waiting = 1'b0;
        check_word({cur_name, " cache addr"}, cur_addr, held.addr);
        check_mask({cur_name, " cache mask"}, exp_mask, held.mask);
        check_size({cur_name, " cache size"}, exp_size, held.size);
        if (held.write) begin
            check_level({cur_name, " write expected"}, exp_write, 1'b1);
            check_word({cur_name, " write data"}, exp_wdata, held.wdata);
            for (int k = 0; k < 4; k++) begin
                if (held.mask[k]) begin
                    mem[{off[5:2], 2'b00} + k] = held.wdata[8*k +: 8];
                end
            end
            writes_seen++;
        end else begin
            // read data right-aligned
            for (int k = 0; k < 4; k++) begin
                if (held.mask[k]) begin
                    rd[8*k +: 8] = mem[off + k];
                end
            end
        end
        resp.rdata = rd;
        resp.ready = 1'b1;
    endtask

    // sample mid cycle, inputs only move just after the rising edge
    always @(negedge clk) begin
        seen = dreq;
        roll = $random(seed);
        if (waiting) begin
            // back-pressure, request and stall hold
            check_level({cur_name, " stall held"}, 1'b1, stall);
            check_level({cur_name, " valid held"}, 1'b1, dreq.valid);
            check_level({cur_name, " write held"}, held.write, dreq.write);
            check_word({cur_name, " addr held"}, held.addr, dreq.addr);
            check_mask({cur_name, " mask held"}, held.mask, dreq.mask);
            check_size({cur_name, " size held"}, held.size, dreq.size);
            check_word({cur_name, " wdata held"}, held.wdata, dreq.wdata);
        end
    end

    // cache response side, 0 to 3 cycles of delay
    always @(posedge clk) begin
        #1;
        if (rst) begin
            resp = '0;
            waiting = 1'b0;
        end else if (resp.ready) begin
            resp = '0;
        end else if (waiting) begin
            if (delay == 2'd0) begin
                serve_access();
            end else begin
                delay = delay - 2'd1;
            end
        end else if (seen.valid) begin
            held = seen;
            if (roll[1:0] == 2'd0) begin
                serve_access();
            end else begin
                waiting = 1'b1;
                delay = roll[1:0] - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d operations done",
                     TIMEOUT_CYCLES, ops_done, N_OPS);
            fail_run();
        end
    end

    // one random op, expected values from the reference copy
    task automatic run_op(input int idx);
        lsu_pkg::lsu_req_t r;
        lsu_pkg::mem_op_e  op;
        lsu_pkg::word_t    rnd;
        logic [5:0]        off;
        logic [7:0]        b;
        logic [15:0]       hw;
        logic              sc_ok;
        @(posedge clk);
        #1;
        rnd = $random(seed);
        op = lsu_pkg::mem_op_e'(rnd[3:0] % 12);
        // lr often followed by its sc
        if (prev_lr && rnd[17]) begin
            op = lsu_pkg::SC_W;
        end
        off = rnd[13:8];
        // reads use the unshifted mask, stores shift it below
        if (op == lsu_pkg::LH || op == lsu_pkg::LHU || op == lsu_pkg::SH) begin
            off[0] = 1'b0;
            exp_mask = 4'b0011;
            exp_size = 4'b0010;
        end else if (op != lsu_pkg::LB && op != lsu_pkg::LBU && op != lsu_pkg::SB) begin
            off[1:0] = 2'b00;
            exp_mask = 4'b1111;
            exp_size = 4'b0100;
        end else begin
            exp_mask = 4'b0001;
            exp_size = 4'b0001;
        end
        r.mem_op = op;
        r.amo_op = lsu_pkg::amo_op_e'(rnd[7:4] % 9);
        r.addr = WIN_BASE | off;
        if (op == lsu_pkg::SC_W && resv_valid && rnd[16]) begin
            r.addr = resv_addr;
            off = resv_addr[5:0];
        end
        r.wdata = $random(seed);
        cur_name = $sformatf("op %0d %s", idx, op.name());
        cur_addr = r.addr;
        exp_write = 1'b0;
        writes_seen = 0;
        result_valid = 1'b1;
        b = ref_mem[off];
        hw = {ref_mem[off + 1], ref_mem[off]};
        case (op)
            lsu_pkg::NONE: exp_result = r.addr;
            lsu_pkg::LB:   exp_result = {{24{b[7]}}, b};
            lsu_pkg::LBU:  exp_result = {24'b0, b};
            lsu_pkg::LH:   exp_result = {{16{hw[15]}}, hw};
            lsu_pkg::LHU:  exp_result = {16'b0, hw};
            lsu_pkg::LW:   exp_result = ref_word(off);
            lsu_pkg::LR_W: begin
                exp_result = ref_word(off);
                resv_valid = 1'b1;
                resv_addr = r.addr;
            end
            lsu_pkg::SC_W: begin
                sc_ok = resv_valid && (resv_addr == r.addr);
                exp_result = sc_ok ? 32'd0 : 32'd1;
                if (sc_ok) begin
                    ref_store(off, 4'b1111, r.wdata);
                end
                resv_valid = 1'b0;
            end
            lsu_pkg::AMO: begin
                exp_result = ref_word(off);
                ref_store(off, 4'b1111, amo_expect(r.amo_op, exp_result, r.wdata));
                resv_valid = 1'b0;
            end
            default: begin
                // plain stores, lane mask and data follow addr[1:0]
                if (op == lsu_pkg::SB) begin
                    ref_store(off, 4'b0001 << off[1:0], r.wdata << (8 * off[1:0]));
                end else if (op == lsu_pkg::SH) begin
                    ref_store(off, 4'b0011 << off[1:0], r.wdata << (8 * off[1:0]));
                end else begin
                    ref_store(off, 4'b1111, r.wdata);
                end
                resv_valid = 1'b0;
                result_valid = 1'b0;
            end
        endcase
        req = r;
        @(negedge clk);
        if (op == lsu_pkg::NONE) begin
            check_level({cur_name, " stall"}, 1'b0, stall);
        end else begin
            check_level({cur_name, " stall"}, 1'b1, stall);
        end
        while (stall) begin
            @(negedge clk);
        end
        if (result_valid) begin
            check_word({cur_name, " result"}, exp_result, result);
        end
        check_level({cur_name, " wrote"}, exp_write, writes_seen != 0);
        prev_lr = (op == lsu_pkg::LR_W);
        ops_done++;
    endtask

    initial begin
        int fill;
        seed = 32'h38d6;
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        resp = '0;
        waiting = 1'b0;
        delay = 2'd0;
        cycle_count = 0;
        ops_done = 0;
        writes_seen = 0;
        resv_valid = 1'b0;
        resv_addr = '0;
        prev_lr = 1'b0;
        exp_write = 1'b0;
        exp_mask = '0;
        exp_size = '0;
        cur_name = "reset";
        for (int i = 0; i < 64; i++) begin
            fill = i * 29 + 60;
            mem[i] = fill[7:0];
            ref_mem[i] = fill[7:0];
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_level("after reset stall", 1'b0, stall);
        check_level("after reset cache valid", 1'b0, dreq.valid);
        for (int i = 0; i < N_OPS; i++) begin
            run_op(i);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
